//--- src.f
sdr_pkg.sv
sdr_apb_regs.sv
dds_channel.sv
dac_source_sel.sv
sdr_core.sv
tb_sdr_core.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the sdr_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_sdr_core
BUILD_DIR=obj_dir
LOG=sim.log

echo "Building $TOP"
verilator --binary --timing -j 0 --top-module "$TOP" -f src.f --Mdir "$BUILD_DIR"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

echo "Running $TOP"
"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# Verdict comes from the log
if grep -q "Test failed" "$LOG"; then
    echo "FAIL"
    exit 1
fi

echo "PASS"
exit 0

//--- tb_sdr_core.sv
`timescale 1ns/1ps

module tb_sdr_core import sdr_pkg::*; ();

    localparam int MAX_CYCLES = 4000;                   // About 800 used, rest is margin

    logic              clk;
    logic              rst;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [31:0]       paddr;
    logic [31:0]       pwdata;
    logic [31:0]       prdata;
    logic signed [7:0] adc_a;
    logic signed [7:0] adc_b;
    logic signed [7:0] dac_a;
    logic signed [7:0] dac_b;

    logic [15:0] lfsr;                                  // Shared random state
    int          errors;
    int          checks;
    int          tests;
    int          test_errs;                             // Error count at test start
    int          cycles;

    // Model register images
    logic [31:0] freq_img [N_DDS];
    logic [31:0] ctrl_img [N_DDS];
    logic [31:0] sel_img;

    sdr_core i_dut (
        .clk_i     (clk),
        .rst_i     (rst),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .adc_a_i   (adc_a),
        .adc_b_i   (adc_b),
        .dac_a_o   (dac_a),
        .dac_b_o   (dac_b)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;                               // 4 ns period

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycles);
            $display("Test failed");
            $finish;
        end
    end

    //////////////////////////////
    // Random source and model
    //////////////////////////////

    // Taps 16,14,13,11, one step per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [7:0] wave_model(input logic [31:0] ph, input logic [1:0] w);
        logic [7:0] t;
        logic [7:0] s;
        t = ph[30:23];
        if (ph[31]) begin
            t = ~t;                                     // Falling half
        end
        case (w)
            2'd0:    s = ph[31:24];                     // Saw
            2'd1:    s = ph[31] ? 8'h80 : 8'h7F;        // Square
            2'd2:    s = t ^ 8'h80;                     // Triangle
            default: s = 8'h00;
        endcase
        return s;
    endfunction

    function automatic logic [7:0] select_model(input logic [2:0] code, input logic [7:0] a,
                                                input logic [7:0] b, input logic [7:0] d0,
                                                input logic [7:0] d1);
        logic [7:0] s;
        case (code)
            3'd1:    s = a;
            3'd2:    s = b;
            3'd3:    s = d0;
            3'd4:    s = d1;
            default: s = 8'h00;                         // Zero and 5..7
        endcase
        return s;
    endfunction

    function automatic logic [31:0] reg_addr(input logic [3:0] blk, input logic [1:0] offs);
        return {APB_BASE, blk, 8'h00, offs, 2'b00};
    endfunction

    function automatic logic [31:0] dds_addr(input int k, input logic [1:0] offs);
        return reg_addr(BLK_DDS0 + 4'(k), offs);
    endfunction

    // Four kinds of address that map to nothing
    function automatic logic [31:0] bad_addr();
        logic [1:0]  kind;
        logic [15:0] upper;
        logic [3:0]  blk;
        logic [31:0] a;
        kind = 2'(lfsr_bits(2));
        case (kind)
            2'd0: begin                                 // Wrong base
                upper = 16'(lfsr_bits(16));
                if (upper == APB_BASE) begin
                    upper = upper ^ 16'h0001;
                end
                a = {upper, 16'(lfsr_bits(16))};
            end
            2'd1: begin                                 // Unused block
                blk = 4'(lfsr_bits(4));
                if (blk == 4'd0 || blk == 4'd1 || blk == 4'd4) begin
                    blk = blk + 4'd2;
                end
                a = {APB_BASE, blk, 12'(lfsr_bits(12))};
            end
            2'd2: a = {APB_BASE, 3'b000, 1'(lfsr_bits(1)), 8'(lfsr_bits(8)), 2'b11,
                       2'(lfsr_bits(2))};               // DDS offset 3
            default: a = {APB_BASE, 4'h4, 8'(lfsr_bits(8)), 1'b1, 1'(lfsr_bits(1)),
                          2'(lfsr_bits(2))};            // Global offset 2 or 3
        endcase
        return a;
    endfunction

    // True if 'to' lies 1..64 frequency steps after 'from'
    function automatic logic phase_reachable(input logic [31:0] from, input logic [31:0] to,
                                             input logic [31:0] f);
        logic [31:0] acc;
        logic        hit;
        acc = from + f;
        hit = 1'b0;
        for (int n = 1; n <= 64; n++) begin
            if (acc == to) begin
                hit = 1'b1;
            end
            acc = acc + f;
        end
        return hit;
    endfunction

    //////////////////////////////
    // Bus tasks and checks
    //////////////////////////////

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
        @(negedge clk);
        psel    = 1'b1;                                 // Setup
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;                                 // Access, write at next edge
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input logic [31:0] addr, output logic [31:0] data);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        #1 data = prdata;                               // Settled, well before the edge
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_steps(input int k, input logic [31:0] from, input logic [31:0] to,
                               input logic [31:0] f);
        checks++;
        if (!phase_reachable(from, to, f)) begin
            $display("Phase of channel %0d moved from 0x%08h to 0x%08h, not a whole number",
                     k, from, to);
            $display("of frequency steps 0x%08h within 64 steps", f);
            errors++;
        end
    endtask

    // Every writable register against its image
    task automatic check_regs();
        logic [31:0] rd;
        for (int k = 0; k < N_DDS; k++) begin
            apb_read(dds_addr(k, REG_FREQ), rd);
            check_value($sformatf("ch%0d freq", k), rd, freq_img[k]);
            apb_read(dds_addr(k, REG_CTRL), rd);
            check_value($sformatf("ch%0d ctrl", k), rd, ctrl_img[k]);
        end
        apb_read(reg_addr(BLK_GLOBAL, REG_DAC_SEL), rd);
        check_value("dac_sel", rd, sel_img);
    endtask

    task automatic test_done(input string name);
        tests++;
        if (errors == test_errs) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: failed with %0d errors", name, errors - test_errs);
        end
        test_errs = errors;
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        logic [31:0] rd;
        logic [31:0] r1;
        logic [31:0] d;
        logic [31:0] p;
        logic [31:0] f;
        logic [2:0]  code_a;
        logic [2:0]  code_b;
        logic [1:0]  wv;
        logic [7:0]  exp_a;
        logic [7:0]  exp_b;
        logic [7:0]  dds_smp [N_DDS];

        rst       = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        adc_a     = '0;
        adc_b     = '0;
        lfsr      = 16'd37544;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        test_errs = 0;
        cycles    = 0;
        for (int k = 0; k < N_DDS; k++) begin
            freq_img[k] = '0;
            ctrl_img[k] = '0;                           // Saw, disabled
        end
        sel_img = '0;

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Reset values, ID and holes in the map
        check_value("dac_a", {24'd0, dac_a}, 32'd0);
        check_value("dac_b", {24'd0, dac_b}, 32'd0);
        apb_read(reg_addr(BLK_GLOBAL, REG_ID), rd);
        check_value("core_id", rd, CORE_ID);
        repeat (12) begin
            apb_read(bad_addr(), rd);
            check_value("unmapped read", rd, 32'd0);
        end
        repeat (12) apb_write(bad_addr(), lfsr_bits(32));
        check_regs();
        for (int k = 0; k < N_DDS; k++) begin
            apb_read(dds_addr(k, REG_PHASE), rd);
            check_value($sformatf("ch%0d phase", k), rd, 32'd0);
        end
        test_done("test 1 reset and unmapped access");

        repeat (6) begin
            for (int k = 0; k < N_DDS; k++) begin
                d = lfsr_bits(32);
                apb_write(dds_addr(k, REG_FREQ), d);
                freq_img[k] = d;
                d = lfsr_bits(32);
                apb_write(dds_addr(k, REG_CTRL), d);
                ctrl_img[k] = d & 32'h0000_0007;        // Enable and wave only
            end
            d = lfsr_bits(32);
            apb_write(reg_addr(BLK_GLOBAL, REG_DAC_SEL), d);
            sel_img = d & 32'h0000_0077;
            check_regs();
        end
        test_done("test 2 register read-back");

        for (int k = 0; k < N_DDS; k++) begin
            repeat (3) begin
                ctrl_img[k] = {29'd0, 2'(lfsr_bits(2)), 1'b0};
                apb_write(dds_addr(k, REG_CTRL), ctrl_img[k]);
                p = lfsr_bits(32);
                apb_write(dds_addr(k, REG_PHASE), p);
                repeat (2) begin
                    apb_read(dds_addr(k, REG_PHASE), rd);
                    check_value($sformatf("ch%0d held phase", k), rd, p);
                end
            end
        end
        test_done("test 3 phase load, disabled");

        for (int k = 0; k < N_DDS; k++) begin
            repeat (3) begin
                f = lfsr_bits(32);
                apb_write(dds_addr(k, REG_FREQ), f);
                freq_img[k] = f;
                ctrl_img[k] = {29'd0, 2'(lfsr_bits(2)), 1'b1};
                apb_write(dds_addr(k, REG_CTRL), ctrl_img[k]);
                p = lfsr_bits(32);
                apb_write(dds_addr(k, REG_PHASE), p);
                apb_read(dds_addr(k, REG_PHASE), rd);
                check_steps(k, p, rd, f);               // From the loaded value
                apb_read(dds_addr(k, REG_PHASE), r1);
                apb_read(dds_addr(k, REG_PHASE), rd);
                check_steps(k, r1, rd, f);              // Between two reads
            end
        end
        test_done("test 4 phase accumulation");

        for (int k = 0; k < N_DDS; k++) begin
            for (int w = 0; w < 4; w++) begin
                for (int dac = 0; dac < 2; dac++) begin
                    ctrl_img[k] = {29'd0, 2'(w), 1'b1};
                    apb_write(dds_addr(k, REG_CTRL), ctrl_img[k]);
                    f = lfsr_bits(32);
                    apb_write(dds_addr(k, REG_FREQ), f);
                    code_a = (dac == 0) ? 3'(3 + k) : 3'd0;
                    code_b = (dac == 1) ? 3'(3 + k) : 3'd0;
                    apb_write(reg_addr(BLK_GLOBAL, REG_DAC_SEL),
                              {25'd0, code_b, 1'b0, code_a});
                    apb_read(dds_addr(k, REG_PHASE), p);
                    // DAC took the wave of p on the edge ending that access
                    exp_a = (dac == 0) ? wave_model(p, 2'(w)) : 8'h00;
                    exp_b = (dac == 1) ? wave_model(p, 2'(w)) : 8'h00;
                    check_value($sformatf("dac_a ch%0d wave%0d", k, w),
                                {24'd0, dac_a}, {24'd0, exp_a});
                    check_value($sformatf("dac_b ch%0d wave%0d", k, w),
                                {24'd0, dac_b}, {24'd0, exp_b});
                end
            end
        end
        test_done("test 5 DDS waveforms on DAC");

        // Frozen DDS samples for the selector test
        for (int k = 0; k < N_DDS; k++) begin
            wv = 2'(lfsr_bits(2));
            apb_write(dds_addr(k, REG_CTRL), {29'd0, wv, 1'b0});
            p = lfsr_bits(32);
            apb_write(dds_addr(k, REG_PHASE), p);
            dds_smp[k] = wave_model(p, wv);
        end
        for (int it = 0; it < 16; it++) begin
            code_a = (it < 8) ? 3'(it) : 3'(lfsr_bits(3));
            code_b = (it < 8) ? 3'(lfsr_bits(3)) : 3'(it - 8);
            apb_write(reg_addr(BLK_GLOBAL, REG_DAC_SEL), {25'd0, code_b, 1'b0, code_a});
            @(negedge clk);
            adc_a = 8'(lfsr_bits(8));
            adc_b = 8'(lfsr_bits(8));
            exp_a = select_model(code_a, adc_a, adc_b, dds_smp[0], dds_smp[1]);
            exp_b = select_model(code_b, adc_a, adc_b, dds_smp[0], dds_smp[1]);
            repeat (2) begin                            // ADC held two cycles
                @(negedge clk);
                check_value($sformatf("dac_a src%0d", code_a), {24'd0, dac_a}, {24'd0, exp_a});
                check_value($sformatf("dac_b src%0d", code_b), {24'd0, dac_b}, {24'd0, exp_b});
            end
        end
        test_done("test 6 DAC source select");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- sdr_core.sv
`timescale 1ns/1ps

module sdr_core import sdr_pkg::*; (
    input  logic                       clk_i,
    input  logic                       rst_i,

    // APB from the processor side
    input  logic                       psel_i,
    input  logic                       penable_i,
    input  logic                       pwrite_i,
    input  logic [APB_W-1:0]           paddr_i,
    input  logic [APB_W-1:0]           pwdata_i,
    output logic [APB_W-1:0]           prdata_o,

    // Sample streams, one per clock
    input  logic signed [SAMPLE_W-1:0] adc_a_i,
    input  logic signed [SAMPLE_W-1:0] adc_b_i,
    output logic signed [SAMPLE_W-1:0] dac_a_o,
    output logic signed [SAMPLE_W-1:0] dac_b_o
);

    logic [N_DDS-1:0][PHASE_W-1:0]  phase;              // Live, back to regs
    logic [N_DDS-1:0][PHASE_W-1:0]  freq;
    logic [N_DDS-1:0][PHASE_W-1:0]  phase_load;
    logic [N_DDS-1:0]               phase_load_en;
    logic [N_DDS-1:0]               enable;
    wave_e                          wave [N_DDS];
    logic [N_DDS-1:0][SAMPLE_W-1:0] dds_sample;
    dac_src_e                       dac_a_src;
    dac_src_e                       dac_b_src;

    //////////////////////////////
    // Register block
    //////////////////////////////

    sdr_apb_regs i_regs (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .psel_i          (psel_i),
        .penable_i       (penable_i),
        .pwrite_i        (pwrite_i),
        .paddr_i         (paddr_i),
        .pwdata_i        (pwdata_i),
        .prdata_o        (prdata_o),
        .phase_i         (phase),
        .freq_o          (freq),
        .phase_load_o    (phase_load),
        .phase_load_en_o (phase_load_en),
        .enable_o        (enable),
        .wave_o          (wave),
        .dac_a_src_o     (dac_a_src),
        .dac_b_src_o     (dac_b_src)
    );

    //////////////////////////////
    // DDS channels
    //////////////////////////////

    for (genvar k = 0; k < N_DDS; k++) begin : g_dds
        dds_channel i_dds (
            .clk_i           (clk_i),
            .rst_i           (rst_i),
            .freq_i          (freq[k]),
            .phase_load_i    (phase_load[k]),
            .phase_load_en_i (phase_load_en[k]),
            .enable_i        (enable[k]),
            .wave_i          (wave[k]),
            .phase_o         (phase[k]),
            .sample_o        (dds_sample[k])        // Combinational from phase
        );
    end

    // Registered DAC buses
    dac_source_sel i_dac_sel (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .adc_a_i      (adc_a_i),
        .adc_b_i      (adc_b_i),
        .dds_sample_i (dds_sample),
        .dac_a_src_i  (dac_a_src),
        .dac_b_src_i  (dac_b_src),
        .dac_a_o      (dac_a_o),
        .dac_b_o      (dac_b_o)
    );

endmodule

//--- dac_source_sel.sv
`timescale 1ns/1ps

module dac_source_sel import sdr_pkg::*; (
    input  logic                          clk_i,
    input  logic                          rst_i,

    // Candidate samples
    input  logic signed [SAMPLE_W-1:0]    adc_a_i,
    input  logic signed [SAMPLE_W-1:0]    adc_b_i,
    input  logic [N_DDS-1:0][SAMPLE_W-1:0] dds_sample_i,

    // Source code per DAC
    input  dac_src_e                      dac_a_src_i,
    input  dac_src_e                      dac_b_src_i,

    output logic signed [SAMPLE_W-1:0]    dac_a_o,
    output logic signed [SAMPLE_W-1:0]    dac_b_o
);

    dac_src_e                   src   [N_DAC];          // Index 0 is DAC A
    logic signed [SAMPLE_W-1:0] pick  [N_DAC];
    logic signed [SAMPLE_W-1:0] dac_q [N_DAC];

    assign src[0] = dac_a_src_i;
    assign src[1] = dac_b_src_i;

    //////////////////////////////
    // Source mux
    //////////////////////////////

    always_comb begin
        for (int d = 0; d < N_DAC; d++) begin
            case (src[d])
                SRC_ADC_A: pick[d] = adc_a_i;
                SRC_ADC_B: pick[d] = adc_b_i;
                SRC_DDS0:  pick[d] = signed'(dds_sample_i[0]);
                SRC_DDS1:  pick[d] = signed'(dds_sample_i[1]);
                default:   pick[d] = '0;                // Zero and codes 5..7
            endcase
        end
    end

    //////////////////////////////
    // Output stage
    //////////////////////////////

    // One clock from selected source to DAC bus
    always_ff @(posedge clk_i) begin
        for (int d = 0; d < N_DAC; d++) begin
            if (rst_i) begin
                dac_q[d] <= '0;
            end else begin
                dac_q[d] <= pick[d];
            end
        end
    end

    assign dac_a_o = dac_q[0];
    assign dac_b_o = dac_q[1];

endmodule

//--- dds_channel.sv
`timescale 1ns/1ps

module dds_channel import sdr_pkg::*; (
    input  logic                       clk_i,
    input  logic                       rst_i,

    input  logic [PHASE_W-1:0]         freq_i,          // Phase step per clock
    input  logic [PHASE_W-1:0]         phase_load_i,
    input  logic                       phase_load_en_i, // One-cycle load strobe
    input  logic                       enable_i,
    input  wave_e                      wave_i,

    output logic [PHASE_W-1:0]         phase_o,
    output logic signed [SAMPLE_W-1:0] sample_o
);

    logic [PHASE_W-1:0]  phase;
    logic                msb;                           // Half-cycle flag
    logic [SAMPLE_W-1:0] saw;
    logic [SAMPLE_W-1:0] square;
    logic [SAMPLE_W-1:0] tri_fold;
    logic [SAMPLE_W-1:0] tri_wave;

    //////////////////////////////
    // Phase accumulator
    //////////////////////////////

    // Load wins over accumulate
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            phase <= '0;
        end else if (phase_load_en_i) begin
            phase <= phase_load_i;
        end else if (enable_i) begin
            phase <= phase + freq_i;                    // Wraps mod 2^32
        end
    end

    assign phase_o = phase;

    //////////////////////////////
    // Wave shaper
    //////////////////////////////

    assign msb = phase[PHASE_W-1];

    // Top byte as two's complement ramp
    assign saw = phase[PHASE_W-1 -: SAMPLE_W];

    // +127 first half, -128 second half
    assign square = {msb, {(SAMPLE_W-1){~msb}}};

    // Fold the next byte down on the second half
    always_comb begin
        tri_fold = phase[PHASE_W-2 -: SAMPLE_W];        // Bits 30:23
        if (msb) begin
            tri_fold = ~tri_fold;
        end
    end

    // Offset binary to signed
    assign tri_wave = {~tri_fold[SAMPLE_W-1], tri_fold[SAMPLE_W-2:0]};

    // No register here, sample follows phase in the same cycle
    always_comb begin
        case (wave_i)
            WAVE_SAW:      sample_o = signed'(saw);
            WAVE_SQUARE:   sample_o = signed'(square);
            WAVE_TRIANGLE: sample_o = signed'(tri_wave);
            default:       sample_o = '0;               // WAVE_ZERO
        endcase
    end

endmodule

//--- sdr_apb_regs.sv
`timescale 1ns/1ps

module sdr_apb_regs import sdr_pkg::*; (
    input  logic                          clk_i,
    input  logic                          rst_i,

    // APB slave, no wait states
    input  logic                          psel_i,
    input  logic                          penable_i,
    input  logic                          pwrite_i,
    input  logic [APB_W-1:0]              paddr_i,
    input  logic [APB_W-1:0]              pwdata_i,
    output logic [APB_W-1:0]              prdata_o,

    // DDS channel controls
    input  logic [N_DDS-1:0][PHASE_W-1:0] phase_i,
    output logic [N_DDS-1:0][PHASE_W-1:0] freq_o,
    output logic [N_DDS-1:0][PHASE_W-1:0] phase_load_o,
    output logic [N_DDS-1:0]              phase_load_en_o,
    output logic [N_DDS-1:0]              enable_o,
    output wave_e                         wave_o [N_DDS],

    // DAC source codes
    output dac_src_e                      dac_a_src_o,
    output dac_src_e                      dac_b_src_o
);

    logic             access;                           // Second APB phase
    logic             wr_en;
    logic             base_hit;
    logic [3:0]       blk;
    logic [1:0]       offs;
    logic [N_DDS-1:0] dds_hit;
    logic             glb_hit;
    logic [APB_W-1:0] rdata;

    //////////////////////////////
    // Decode
    //////////////////////////////

    assign access   = psel_i & penable_i;
    assign wr_en    = access & pwrite_i;
    assign base_hit = (paddr_i[31:16] == APB_BASE);
    assign blk      = paddr_i[15:12];
    assign offs     = paddr_i[3:2];                     // Word offset in block
    assign glb_hit  = base_hit & (blk == BLK_GLOBAL);

    always_comb begin
        for (int k = 0; k < N_DDS; k++) begin
            dds_hit[k] = base_hit & (blk == BLK_DDS0 + 4'(k));
        end
    end

    // Load strobe lives in the access cycle itself, phase takes it on that edge
    always_comb begin
        for (int k = 0; k < N_DDS; k++) begin
            phase_load_en_o[k] = wr_en & dds_hit[k] & (offs == REG_PHASE);
            phase_load_o[k]    = pwdata_i;              // Same payload for all channels
        end
    end

    //////////////////////////////
    // Write side
    //////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int k = 0; k < N_DDS; k++) begin
                freq_o[k]   <= '0;
                enable_o[k] <= 1'b0;
                wave_o[k]   <= WAVE_SAW;
            end
            dac_a_src_o <= SRC_ZERO;
            dac_b_src_o <= SRC_ZERO;
        end else if (wr_en) begin
            for (int k = 0; k < N_DDS; k++) begin
                if (dds_hit[k]) begin
                    case (offs)
                        REG_FREQ: freq_o[k] <= pwdata_i;
                        REG_CTRL: begin
                            enable_o[k] <= pwdata_i[0];
                            wave_o[k]   <= wave_e'(pwdata_i[2:1]);
                        end
                        default: ;                      // Phase handled by strobe
                    endcase
                end
            end
            if (glb_hit && (offs == REG_DAC_SEL)) begin
                dac_a_src_o <= dac_src_e'(pwdata_i[2:0]);
                dac_b_src_o <= dac_src_e'(pwdata_i[6:4]);
            end
        end
    end

    //////////////////////////////
    // Read-back
    //////////////////////////////

    always_comb begin
        rdata = '0;                                     // Unmapped reads as zero
        for (int k = 0; k < N_DDS; k++) begin
            if (dds_hit[k]) begin
                case (offs)
                    REG_FREQ:  rdata = freq_o[k];
                    REG_PHASE: rdata = phase_i[k];      // Live accumulator
                    REG_CTRL:  rdata = {29'd0, wave_o[k], enable_o[k]};
                    default:   rdata = '0;
                endcase
            end
        end
        if (glb_hit) begin
            case (offs)
                REG_DAC_SEL: rdata = {25'd0, dac_b_src_o, 1'b0, dac_a_src_o};
                REG_ID:      rdata = CORE_ID;
                default:     rdata = '0;
            endcase
        end
    end

    // Bus idles at zero outside the access phase
    assign prdata_o = access ? rdata : '0;

endmodule

//--- sdr_pkg.sv
package sdr_pkg;

    //////////////////////////////
    // Sizes
    //////////////////////////////

    localparam int N_DDS    = 2;                        // DDS channels
    localparam int N_DAC    = 2;                        // DAC outputs
    localparam int SAMPLE_W = 8;                        // Signed sample width
    localparam int PHASE_W  = 32;                       // Accumulator and freq word
    localparam int APB_W    = 32;                       // APB addr and data

    //////////////////////////////
    // Address map
    //////////////////////////////

    // Upper half of paddr must match for any access
    localparam logic [15:0] APB_BASE = 16'h43C0;

    // Block codes on paddr[15:12]
    localparam logic [3:0] BLK_DDS0   = 4'h0;           // Channel k at BLK_DDS0+k
    localparam logic [3:0] BLK_GLOBAL = 4'h4;

    // Offsets on paddr[3:2], DDS block
    localparam logic [1:0] REG_FREQ  = 2'd0;
    localparam logic [1:0] REG_PHASE = 2'd1;            // Write loads, read is live
    localparam logic [1:0] REG_CTRL  = 2'd2;            // [0] enable, [2:1] wave

    // Offsets on paddr[3:2], global block
    localparam logic [1:0] REG_DAC_SEL = 2'd0;          // [2:0] DAC A, [6:4] DAC B
    localparam logic [1:0] REG_ID      = 2'd1;

    localparam logic [31:0] CORE_ID = 32'h5244_0001;

    //////////////////////////////
    // Encodings
    //////////////////////////////

    typedef enum logic [1:0] {
        WAVE_SAW      = 2'd0,
        WAVE_SQUARE   = 2'd1,
        WAVE_TRIANGLE = 2'd2,
        WAVE_ZERO     = 2'd3
    } wave_e;

    // Codes 5..7 unused, decode as zero
    typedef enum logic [2:0] {
        SRC_ZERO  = 3'd0,
        SRC_ADC_A = 3'd1,
        SRC_ADC_B = 3'd2,
        SRC_DDS0  = 3'd3,
        SRC_DDS1  = 3'd4
    } dac_src_e;

endpackage
